/* tiler_pkg.sv */
/*
  GEMM tiler package
  Array geometry constants, operation and format encodings, and the
  packed structs exchanged between the tiler units
*/
package tiler_pkg;

  // Compute array shape
  localparam int unsigned ARRAY_WIDTH  = 12;
  localparam int unsigned ARRAY_HEIGHT = 4;
  localparam int unsigned PIPE_REGS    = 3;
  localparam int unsigned TILE         = ARRAY_HEIGHT * (PIPE_REGS + 1);
  localparam int unsigned ELEM_BYTES   = 2;

  localparam int unsigned SIZE_W     = 16;
  localparam int unsigned MULT_A_W   = 16;
  localparam int unsigned MULT_B_W   = 32;
  localparam int unsigned PROD_W     = MULT_A_W + MULT_B_W;
  localparam int unsigned MULT_CNT_W = $clog2(MULT_A_W);

  typedef logic [SIZE_W-1:0]     size_t;
  typedef logic [31:0]           word_t;
  typedef logic [PROD_W-1:0]     prod_t;
  typedef logic [MULT_CNT_W-1:0] mult_cnt_t;

  typedef enum logic [2:0] {
    MATMUL, GEMM, ADDMAX, ADDMIN, MULMAX, MULMIN, MAXMIN
  } gemm_op_e;

  typedef enum logic [2:0] {
    FLOAT16, FLOAT8, FLOAT16ALT, FLOAT8ALT
  } gemm_fmt_e;

  // FPU operation codes, as the FPU expects them
  typedef enum logic [4:0] {
    FMADD  = 5'd0,
    ADD    = 5'd2,
    MUL    = 5'd3,
    MINMAX = 5'd7
  } fpu_op_e;

  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1
  } rnd_e;

  typedef enum logic [2:0] {
    FP16    = 3'd2,
    FP8     = 3'd3,
    FP16ALT = 3'd4,
    FP8ALT  = 3'd5
  } fpu_fmt_e;

  typedef struct packed {
    size_t     m_size;
    size_t     k_size;
    size_t     n_size;
    gemm_op_e  gemm_op;
    gemm_fmt_e input_fmt;
  } tiler_cfg_t;

  typedef struct packed {
    size_t      x_rows_iter;
    size_t      x_cols_iter;
    size_t      w_rows_iter;
    size_t      w_cols_iter;
    logic [7:0] x_rows_lftovr;
    logic [7:0] x_cols_lftovr;
    logic [7:0] w_rows_lftovr;
    logic [7:0] w_cols_lftovr;
    logic [7:0] x_buffer_slots;
    word_t      x_d1_stride;
    word_t      x_rows_offs;
    word_t      w_d0_stride;
    word_t      z_d2_stride;
  } tiler_geom_t;

  typedef struct packed {
    fpu_op_e  stage_1_op;
    fpu_op_e  stage_2_op;
    rnd_e     stage_1_rnd;
    rnd_e     stage_2_rnd;
    fpu_fmt_e compute_fmt;
    logic     gemm_selection;
  } tiler_op_sel_t;

  typedef struct packed {
    size_t tot_stores;
    word_t tot_x_read;
    word_t w_tot_len;
    word_t z_tot_len;
  } tiler_counts_t;

  typedef struct packed {
    tiler_geom_t   geom;
    tiler_op_sel_t op_sel;
    tiler_counts_t counts;
  } tiler_result_t;

endpackage

/* tiler_geometry.sv */
/*
  Tiler geometry
  Iteration counts, leftovers, X buffer slots and memory strides
  derived from the matrix sizes
*/
`timescale 1ns/100ps

module tiler_geometry (
  input  tiler_pkg::tiler_cfg_t  cfg_i,
  output tiler_pkg::tiler_geom_t geom_o
);

  tiler_pkg::size_t x_rows_full, x_cols_full, w_cols_full;
  tiler_pkg::size_t x_rows_rem, x_cols_rem, w_cols_rem, w_rows_rem;
  tiler_pkg::size_t slots;
  tiler_pkg::word_t x_stride, w_stride;

  // Whole tiles along each dimension
  assign x_rows_full = cfg_i.m_size / tiler_pkg::size_t'(tiler_pkg::ARRAY_WIDTH);
  assign x_cols_full = cfg_i.n_size / tiler_pkg::size_t'(tiler_pkg::TILE);
  assign w_cols_full = cfg_i.k_size / tiler_pkg::size_t'(tiler_pkg::TILE);

  assign x_rows_rem = cfg_i.m_size % tiler_pkg::size_t'(tiler_pkg::ARRAY_WIDTH);
  assign x_cols_rem = cfg_i.n_size % tiler_pkg::size_t'(tiler_pkg::TILE);
  assign w_cols_rem = cfg_i.k_size % tiler_pkg::size_t'(tiler_pkg::TILE);
  assign w_rows_rem = cfg_i.n_size % tiler_pkg::size_t'(tiler_pkg::ARRAY_HEIGHT);

  // A partial tile costs one more iteration
  assign geom_o.x_rows_iter = x_rows_full + tiler_pkg::size_t'(x_rows_rem != '0);
  assign geom_o.x_cols_iter = x_cols_full + tiler_pkg::size_t'(x_cols_rem != '0);
  assign geom_o.w_cols_iter = w_cols_full + tiler_pkg::size_t'(w_cols_rem != '0);

  // W rows padded up to a multiple of the array height
  assign geom_o.w_rows_iter = (w_rows_rem == '0) ? cfg_i.n_size :
      cfg_i.n_size + tiler_pkg::size_t'(tiler_pkg::ARRAY_HEIGHT) - w_rows_rem;

  assign geom_o.x_rows_lftovr = x_rows_rem[7:0];
  assign geom_o.x_cols_lftovr = x_cols_rem[7:0];
  assign geom_o.w_cols_lftovr = w_cols_rem[7:0];
  assign geom_o.w_rows_lftovr = w_rows_rem[7:0];

  // Column leftover rounded up to whole array columns
  assign slots = (x_cols_rem + tiler_pkg::size_t'(tiler_pkg::ARRAY_HEIGHT - 1))
               / tiler_pkg::size_t'(tiler_pkg::ARRAY_HEIGHT)
               * tiler_pkg::size_t'(tiler_pkg::ARRAY_HEIGHT);
  assign geom_o.x_buffer_slots = slots[7:0];

  // Byte strides in memory
  assign x_stride = tiler_pkg::word_t'(tiler_pkg::ELEM_BYTES) * tiler_pkg::word_t'(cfg_i.n_size);
  assign w_stride = tiler_pkg::word_t'(tiler_pkg::ELEM_BYTES) * tiler_pkg::word_t'(cfg_i.k_size);

  assign geom_o.x_d1_stride = x_stride;
  assign geom_o.x_rows_offs = tiler_pkg::word_t'(tiler_pkg::ARRAY_WIDTH) * x_stride;
  assign geom_o.w_d0_stride = w_stride;
  assign geom_o.z_d2_stride = tiler_pkg::word_t'(tiler_pkg::ARRAY_WIDTH) * w_stride;

endmodule

/* tiler_op_decode.sv */
/*
  Tiler operation decoder
  Maps the GEMM operation code and input format onto the FPU stage
  operations, rounding modes and compute format
*/
`timescale 1ns/100ps

module tiler_op_decode (
  input  tiler_pkg::tiler_cfg_t    cfg_i,
  output tiler_pkg::tiler_op_sel_t op_sel_o
);

  always_comb begin
    // Second stage always reduces with min/max
    op_sel_o.stage_2_op     = tiler_pkg::MINMAX;
    op_sel_o.stage_1_op     = tiler_pkg::MINMAX;
    op_sel_o.stage_1_rnd    = tiler_pkg::RTZ;
    op_sel_o.stage_2_rnd    = tiler_pkg::RNE;
    op_sel_o.gemm_selection = (cfg_i.gemm_op != tiler_pkg::MATMUL);

    case (cfg_i.gemm_op)
      tiler_pkg::MATMUL, tiler_pkg::GEMM: begin
        op_sel_o.stage_1_op  = tiler_pkg::FMADD;
        op_sel_o.stage_1_rnd = tiler_pkg::RNE;
      end
      tiler_pkg::ADDMAX, tiler_pkg::ADDMIN: begin
        op_sel_o.stage_1_op  = tiler_pkg::ADD;
        op_sel_o.stage_1_rnd = tiler_pkg::RNE;
      end
      tiler_pkg::MULMAX, tiler_pkg::MULMIN: begin
        op_sel_o.stage_1_op  = tiler_pkg::MUL;
        op_sel_o.stage_1_rnd = tiler_pkg::RNE;
      end
      default: ;
    endcase

    // RTZ on the second stage selects max
    if (cfg_i.gemm_op == tiler_pkg::ADDMAX || cfg_i.gemm_op == tiler_pkg::MULMAX) begin
      op_sel_o.stage_2_rnd = tiler_pkg::RTZ;
    end

    case (cfg_i.input_fmt)
      tiler_pkg::FLOAT16:    op_sel_o.compute_fmt = tiler_pkg::FP16;
      tiler_pkg::FLOAT8:     op_sel_o.compute_fmt = tiler_pkg::FP8;
      tiler_pkg::FLOAT16ALT: op_sel_o.compute_fmt = tiler_pkg::FP16ALT;
      default:               op_sel_o.compute_fmt = tiler_pkg::FP8ALT;
    endcase
  end

endmodule

/* tiler_seq_mult.sv */
/*
  Sequential shift-add multiplier
  Examines one bit of A per cycle and accumulates B shifted by the
  bit position; done pulses once with the full product
*/
`timescale 1ns/100ps

module tiler_seq_mult (
  input  logic                              clk_int,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  input  logic                              start_i,
  input  logic [tiler_pkg::MULT_A_W-1:0]    a_i,
  input  logic [tiler_pkg::MULT_B_W-1:0]    b_i,
  output logic                              busy_o,
  output logic                              done_o,
  output tiler_pkg::prod_t                  prod_o
);

  logic                           busy_q, done_q;
  tiler_pkg::mult_cnt_t           cnt_q;
  logic [tiler_pkg::MULT_A_W-1:0] a_q;
  tiler_pkg::prod_t               b_q, acc_q;
  logic                           last_bit;

  assign last_bit = (cnt_q == tiler_pkg::mult_cnt_t'(tiler_pkg::MULT_A_W - 1));

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (clear_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= busy_q & last_bit;
      if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (last_bit) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // Operand and accumulator datapath
  always_ff @(posedge clk_int) begin
    if (start_i) begin
      a_q   <= a_i;
      b_q   <= tiler_pkg::prod_t'(b_i);
      acc_q <= '0;
    end else if (busy_q) begin
      if (a_q[0]) begin
        acc_q <= acc_q + b_q;
      end
      a_q <= a_q >> 1;
      b_q <= b_q << 1;
    end
  end

  assign busy_o = busy_q;
  assign done_o = done_q;
  assign prod_o = acc_q;

  // The sequencer must wait for the previous product
  a_start_idle: assert property (@(posedge clk_int) disable iff (!rst_ni)
    start_i |-> !busy_o);

endmodule

/* tiler_product_seq.sv */
/*
  Loop product sequencer
  Runs the three loop products one after another on a single
  shift-add multiplier and assembles the count fields
*/
`timescale 1ns/100ps

module tiler_product_seq (
  input  logic                      clk_int,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      go_i,
  input  tiler_pkg::tiler_geom_t    geom_i,
  output logic                      done_o,
  output tiler_pkg::tiler_counts_t  counts_o
);

  typedef enum logic [1:0] {
    IDLE, STEP1, STEP2, STEP3
  } state_e;

  state_e                         state_q;
  logic                           start_q, done_q;
  logic                           mult_start, mult_done;
  logic [tiler_pkg::MULT_A_W-1:0] mult_a;
  logic [tiler_pkg::MULT_B_W-1:0] mult_b;
  tiler_pkg::prod_t               mult_prod;
  tiler_pkg::word_t               p1_q, x_read_q, w_len_q;

  // First step issues straight from go, later ones a cycle after done
  assign mult_start = (state_q == IDLE && go_i) || start_q;

  always_comb begin
    case (state_q)
      STEP2: begin
        mult_a = geom_i.x_cols_iter;
        mult_b = p1_q;
      end
      STEP3: begin
        mult_a = geom_i.w_rows_iter;
        mult_b = p1_q;
      end
      default: begin
        mult_a = geom_i.x_rows_iter;
        mult_b = tiler_pkg::word_t'(geom_i.w_cols_iter);
      end
    endcase
  end

  tiler_seq_mult u_mult (
    .clk_int (clk_int),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .start_i (mult_start),
    .a_i     (mult_a),
    .b_i     (mult_b),
    .busy_o  (),
    .done_o  (mult_done),
    .prod_o  (mult_prod)
  );

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else if (clear_i) begin
      state_q <= IDLE;
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      start_q <= 1'b0;
      done_q  <= 1'b0;
      case (state_q)
        IDLE:  if (go_i) state_q <= STEP1;
        STEP1: if (mult_done) begin
          state_q <= STEP2;
          start_q <= 1'b1;
        end
        STEP2: if (mult_done) begin
          state_q <= STEP3;
          start_q <= 1'b1;
        end
        STEP3: if (mult_done) begin
          state_q <= IDLE;
          done_q  <= 1'b1;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Products keep their low word only
  always_ff @(posedge clk_int) begin
    if (mult_done) begin
      case (state_q)
        STEP1:   p1_q     <= mult_prod[31:0];
        STEP2:   x_read_q <= mult_prod[31:0];
        STEP3:   w_len_q  <= mult_prod[31:0];
        default: ;
      endcase
    end
  end

  assign done_o              = done_q;
  assign counts_o.tot_stores = p1_q[tiler_pkg::SIZE_W-1:0];
  assign counts_o.tot_x_read = x_read_q;
  assign counts_o.w_tot_len  = w_len_q;
  assign counts_o.z_tot_len  = tiler_pkg::word_t'(tiler_pkg::ARRAY_WIDTH) * p1_q;

  a_done_single: assert property (@(posedge clk_int) disable iff (!rst_ni)
    done_o |=> !done_o);

endmodule

/* tiler_top.sv */
/*
  GEMM tiler top
  Latches a request on start, derives geometry and operation select,
  runs the loop products and presents the registered result with valid
*/
`timescale 1ns/100ps

module tiler_top (
  input  logic                      clk_int,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      start_i,
  input  tiler_pkg::tiler_cfg_t     cfg_i,
  output logic                      ready_o,
  output logic                      valid_o,
  output tiler_pkg::tiler_result_t  result_o
);

  tiler_pkg::tiler_cfg_t    req_q;
  tiler_pkg::tiler_geom_t   geom;
  tiler_pkg::tiler_op_sel_t op_sel;
  tiler_pkg::tiler_counts_t counts;
  tiler_pkg::tiler_result_t result_q;
  logic                     busy_q, go_q, valid_q;
  logic                     accept, seq_done;

  assign accept  = start_i && !busy_q;
  assign ready_o = !busy_q;

  // Request register, held for the whole computation
  always_ff @(posedge clk_int) begin
    if (accept) begin
      req_q <= cfg_i;
    end
  end

  tiler_geometry u_geometry (
    .cfg_i  (req_q),
    .geom_o (geom)
  );

  tiler_op_decode u_op_decode (
    .cfg_i    (req_q),
    .op_sel_o (op_sel)
  );

  tiler_product_seq u_product_seq (
    .clk_int  (clk_int),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .go_i     (go_q),
    .geom_i   (geom),
    .done_o   (seq_done),
    .counts_o (counts)
  );

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      go_q     <= 1'b0;
      valid_q  <= 1'b0;
      result_q <= '0;
    end else if (clear_i) begin
      busy_q   <= 1'b0;
      go_q     <= 1'b0;
      valid_q  <= 1'b0;
      result_q <= '0;
    end else begin
      // go follows acceptance once req_q has loaded
      go_q    <= accept;
      valid_q <= seq_done;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (seq_done) begin
        busy_q   <= 1'b0;
        result_q <= '{geom: geom, op_sel: op_sel, counts: counts};
      end
    end
  end

  assign valid_o  = valid_q;
  assign result_o = result_q;

  a_valid_after_busy: assert property (@(posedge clk_int) disable iff (!rst_ni)
    valid_o |-> $past(busy_q));

endmodule

/* tb_tiler_model.svh */
/*
  GEMM tiler testbench model
  Expected geometry, operation select and loop counts, and the table
  of directed cases applied by the testbench
*/
`ifndef TB_TILER_MODEL_SVH
`define TB_TILER_MODEL_SVH

localparam int NUM_CASES = 8;

// Columns: name, then M, K, N, operation, input format
string case_name [NUM_CASES] = '{
  "exact_tiles", "all_leftovers", "unit_sizes", "addmin_fp8alt",
  "mulmax_small", "mulmin_wide", "maxmin_long_k", "matmul_odd"
};

tiler_pkg::tiler_cfg_t case_cfg [NUM_CASES] = '{
  '{16'd24,  16'd32,  16'd48,  tiler_pkg::MATMUL, tiler_pkg::FLOAT16},
  '{16'd25,  16'd35,  16'd50,  tiler_pkg::GEMM,   tiler_pkg::FLOAT8},
  '{16'd1,   16'd1,   16'd1,   tiler_pkg::ADDMAX, tiler_pkg::FLOAT16ALT},
  '{16'd100, 16'd70,  16'd33,  tiler_pkg::ADDMIN, tiler_pkg::FLOAT8ALT},
  '{16'd12,  16'd16,  16'd4,   tiler_pkg::MULMAX, tiler_pkg::FLOAT16},
  '{16'd200, 16'd129, 16'd17,  tiler_pkg::MULMIN, tiler_pkg::FLOAT8},
  '{16'd7,   16'd300, 16'd255, tiler_pkg::MAXMIN, tiler_pkg::FLOAT16ALT},
  '{16'd13,  16'd17,  16'd5,   tiler_pkg::MATMUL, tiler_pkg::FLOAT8ALT}
};

// Array of 12 rows by 4 columns, tiles of 16, 2 bytes per element
function automatic tiler_pkg::tiler_geom_t model_geom(tiler_pkg::tiler_cfg_t cfg);
  tiler_pkg::tiler_geom_t g;
  int m;
  int k;
  int n;
  int r;
  m = int'(cfg.m_size);
  k = int'(cfg.k_size);
  n = int'(cfg.n_size);
  r = n % 4;
  g.x_rows_iter    = 16'((m + 11) / 12);
  g.x_cols_iter    = 16'((n + 15) / 16);
  g.w_cols_iter    = 16'((k + 15) / 16);
  g.w_rows_iter    = 16'((r == 0) ? n : n + 4 - r);
  g.x_rows_lftovr  = 8'(m % 12);
  g.x_cols_lftovr  = 8'(n % 16);
  g.w_cols_lftovr  = 8'(k % 16);
  g.w_rows_lftovr  = 8'(r);
  g.x_buffer_slots = 8'(((n % 16) + 3) / 4 * 4);
  g.x_d1_stride    = 32'(2 * n);
  g.x_rows_offs    = 32'(24 * n);
  g.w_d0_stride    = 32'(2 * k);
  g.z_d2_stride    = 32'(24 * k);
  return g;
endfunction

function automatic tiler_pkg::tiler_op_sel_t model_op_sel(tiler_pkg::tiler_cfg_t cfg);
  tiler_pkg::tiler_op_sel_t s;
  s.stage_2_op     = tiler_pkg::MINMAX;
  s.stage_1_rnd    = tiler_pkg::RNE;
  s.stage_2_rnd    = tiler_pkg::RNE;
  s.gemm_selection = (cfg.gemm_op != tiler_pkg::MATMUL);
  case (cfg.gemm_op)
    tiler_pkg::MATMUL, tiler_pkg::GEMM: s.stage_1_op = tiler_pkg::FMADD;
    tiler_pkg::ADDMAX: begin
      s.stage_1_op  = tiler_pkg::ADD;
      s.stage_2_rnd = tiler_pkg::RTZ;
    end
    tiler_pkg::ADDMIN: s.stage_1_op = tiler_pkg::ADD;
    tiler_pkg::MULMAX: begin
      s.stage_1_op  = tiler_pkg::MUL;
      s.stage_2_rnd = tiler_pkg::RTZ;
    end
    tiler_pkg::MULMIN: s.stage_1_op = tiler_pkg::MUL;
    default: begin
      s.stage_1_op  = tiler_pkg::MINMAX;
      s.stage_1_rnd = tiler_pkg::RTZ;
    end
  endcase
  case (cfg.input_fmt)
    tiler_pkg::FLOAT16:    s.compute_fmt = tiler_pkg::FP16;
    tiler_pkg::FLOAT8:     s.compute_fmt = tiler_pkg::FP8;
    tiler_pkg::FLOAT16ALT: s.compute_fmt = tiler_pkg::FP16ALT;
    default:               s.compute_fmt = tiler_pkg::FP8ALT;
  endcase
  return s;
endfunction

function automatic tiler_pkg::tiler_counts_t model_counts(tiler_pkg::tiler_geom_t g);
  tiler_pkg::tiler_counts_t c;
  longint p1;
  p1 = longint'(g.x_rows_iter) * longint'(g.w_cols_iter);
  c.tot_stores = 16'(p1);
  c.tot_x_read = 32'(longint'(g.x_cols_iter) * p1);
  c.w_tot_len  = 32'(longint'(g.w_rows_iter) * p1);
  c.z_tot_len  = 32'(12 * p1);
  return c;
endfunction

`endif

/* tb_tiler.sv */
/*
  GEMM tiler testbench
  Applies directed and random requests to the tiler top, checks every
  result field, the handshake timing, ignored starts and clear
*/
`timescale 1ns/100ps

module tb_tiler;

  logic                     clk_int;
  logic                     rst_ni;
  logic                     clear_i;
  logic                     start_i;
  tiler_pkg::tiler_cfg_t    cfg_i;
  logic                     ready_o;
  logic                     valid_o;
  tiler_pkg::tiler_result_t result_o;

  int errors = 0;
  int cycles = 0;
  int seed   = 27825;

  `include "tb_tiler_model.svh"

  localparam int NUM_RANDOM = 20;
  // Accepting edge to the edge that raises valid_o
  localparam int LATENCY = 55;
  localparam int TIMEOUT_CYCLES = (NUM_CASES + NUM_RANDOM + 3) * 70;

  tiler_top uut (
    .clk_int  (clk_int),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .start_i  (start_i),
    .cfg_i    (cfg_i),
    .ready_o  (ready_o),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

  initial begin
    clk_int = 1'b0;
    forever #2 clk_int = ~clk_int;
  end

  always @(posedge clk_int) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors: %0d", errors + 1);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic check_value(string name, string field, logic [31:0] expected,
                             logic [31:0] actual);
    if (expected !== actual) begin
      errors = errors + 1;
      $display("Fail %s %s: expected %0h, actual %0h", name, field, expected, actual);
    end
  endtask

  // Drives one start pulse and returns on the edge that samples it
  task automatic start_request(tiler_pkg::tiler_cfg_t cfg);
    @(posedge clk_int);
    cfg_i   <= cfg;
    start_i <= 1'b1;
    @(posedge clk_int);
    start_i <= 1'b0;
  endtask

  task automatic wait_valid(output int lat);
    logic ready_seen;
    ready_seen = 1'b0;
    lat = 0;
    @(negedge clk_int);
    while (!valid_o) begin
      if (ready_o) begin
        ready_seen = 1'b1;
      end
      lat = lat + 1;
      @(negedge clk_int);
    end
    if (ready_seen) begin
      errors = errors + 1;
      $display("ready_o was high while a request was in progress");
    end
  endtask

  task automatic watch_no_valid(string what, int n);
    repeat (n) begin
      @(negedge clk_int);
      if (valid_o) begin
        errors = errors + 1;
        $display("Unexpected valid_o after %s", what);
      end
    end
  endtask

  task automatic check_result(string name, tiler_pkg::tiler_cfg_t cfg);
    tiler_pkg::tiler_geom_t   g;
    tiler_pkg::tiler_op_sel_t s;
    tiler_pkg::tiler_counts_t c;
    tiler_pkg::tiler_result_t r;
    g = model_geom(cfg);
    s = model_op_sel(cfg);
    c = model_counts(g);
    r = result_o;
    check_value(name, "x_rows_iter", 32'(g.x_rows_iter), 32'(r.geom.x_rows_iter));
    check_value(name, "x_cols_iter", 32'(g.x_cols_iter), 32'(r.geom.x_cols_iter));
    check_value(name, "w_rows_iter", 32'(g.w_rows_iter), 32'(r.geom.w_rows_iter));
    check_value(name, "w_cols_iter", 32'(g.w_cols_iter), 32'(r.geom.w_cols_iter));
    check_value(name, "x_rows_lftovr", 32'(g.x_rows_lftovr), 32'(r.geom.x_rows_lftovr));
    check_value(name, "x_cols_lftovr", 32'(g.x_cols_lftovr), 32'(r.geom.x_cols_lftovr));
    check_value(name, "w_rows_lftovr", 32'(g.w_rows_lftovr), 32'(r.geom.w_rows_lftovr));
    check_value(name, "w_cols_lftovr", 32'(g.w_cols_lftovr), 32'(r.geom.w_cols_lftovr));
    check_value(name, "x_buffer_slots", 32'(g.x_buffer_slots), 32'(r.geom.x_buffer_slots));
    check_value(name, "x_d1_stride", g.x_d1_stride, r.geom.x_d1_stride);
    check_value(name, "x_rows_offs", g.x_rows_offs, r.geom.x_rows_offs);
    check_value(name, "w_d0_stride", g.w_d0_stride, r.geom.w_d0_stride);
    check_value(name, "z_d2_stride", g.z_d2_stride, r.geom.z_d2_stride);
    check_value(name, "stage_1_op", 32'(s.stage_1_op), 32'(r.op_sel.stage_1_op));
    check_value(name, "stage_2_op", 32'(s.stage_2_op), 32'(r.op_sel.stage_2_op));
    check_value(name, "stage_1_rnd", 32'(s.stage_1_rnd), 32'(r.op_sel.stage_1_rnd));
    check_value(name, "stage_2_rnd", 32'(s.stage_2_rnd), 32'(r.op_sel.stage_2_rnd));
    check_value(name, "compute_fmt", 32'(s.compute_fmt), 32'(r.op_sel.compute_fmt));
    check_value(name, "gemm_selection", 32'(s.gemm_selection),
                32'(r.op_sel.gemm_selection));
    check_value(name, "tot_stores", 32'(c.tot_stores), 32'(r.counts.tot_stores));
    check_value(name, "tot_x_read", c.tot_x_read, r.counts.tot_x_read);
    check_value(name, "w_tot_len", c.w_tot_len, r.counts.w_tot_len);
    check_value(name, "z_tot_len", c.z_tot_len, r.counts.z_tot_len);
  endtask

  task automatic run_case(string name, tiler_pkg::tiler_cfg_t cfg);
    int                       lat;
    tiler_pkg::tiler_result_t held;
    start_request(cfg);
    wait_valid(lat);
    check_value(name, "latency", 32'(LATENCY), 32'(lat));
    if (!ready_o) begin
      errors = errors + 1;
      $display("ready_o did not return high together with valid_o in %s", name);
    end
    check_result(name, cfg);
    held = result_o;
    @(negedge clk_int);
    if (valid_o) begin
      errors = errors + 1;
      $display("valid_o stayed high for more than one cycle in %s", name);
    end
    repeat (3) @(negedge clk_int);
    if (result_o !== held) begin
      errors = errors + 1;
      $display("result_o changed while idle after %s", name);
    end
  endtask

  initial begin
    string                 rname;
    tiler_pkg::tiler_cfg_t rcfg;
    int                    lat;
    rst_ni  = 1'b0;
    clear_i = 1'b0;
    start_i = 1'b0;
    cfg_i   = '0;
    repeat (4) @(posedge clk_int);
    rst_ni <= 1'b1;
    @(negedge clk_int);
    if (!ready_o || valid_o) begin
      errors = errors + 1;
      $display("ready_o is not high or valid_o is not low after reset");
    end

    for (int i = 0; i < NUM_CASES; i++) begin
      run_case(case_name[i], case_cfg[i]);
    end

    // A start while busy must not replace the running request
    start_request(case_cfg[1]);
    repeat (5) @(posedge clk_int);
    start_request(case_cfg[6]);
    wait_valid(lat);
    check_result("back_to_back", case_cfg[1]);
    watch_no_valid("an ignored start", 60);

    // Abort in mid-computation
    start_request(case_cfg[2]);
    repeat (20) @(posedge clk_int);
    clear_i <= 1'b1;
    @(posedge clk_int);
    clear_i <= 1'b0;
    @(negedge clk_int);
    if (!ready_o) begin
      errors = errors + 1;
      $display("ready_o did not return high after clear_i");
    end
    if (result_o !== '0) begin
      errors = errors + 1;
      $display("result_o was not zeroed by clear_i");
    end
    watch_no_valid("clear_i", 60);

    // Sizes up to 1024 keep every product inside 32 bits
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rname = $sformatf("random_%0d", i);
      rcfg.m_size    = 16'(1 + $unsigned($random(seed)) % 1024);
      rcfg.k_size    = 16'(1 + $unsigned($random(seed)) % 1024);
      rcfg.n_size    = 16'(1 + $unsigned($random(seed)) % 1024);
      rcfg.gemm_op   = tiler_pkg::gemm_op_e'(3'($unsigned($random(seed)) % 7));
      rcfg.input_fmt = tiler_pkg::gemm_fmt_e'(3'($unsigned($random(seed)) % 4));
      run_case(rname, rcfg);
    end

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+.
tiler_pkg.sv
tiler_geometry.sv
tiler_op_decode.sv
tiler_seq_mult.sv
tiler_product_seq.sv
tiler_top.sv
tb_tiler.sv

/* Makefile */
SRCS = $(wildcard *.sv) tb_tiler_model.svh compile.f

.PHONY: all run lint clean

all: run

obj_dir/Vtb_tiler: $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f compile.f --top-module tb_tiler -o Vtb_tiler

run: obj_dir/Vtb_tiler
	./obj_dir/Vtb_tiler | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f compile.f --top-module tiler_top

clean:
	rm -rf obj_dir sim.log
